// ==== all.f ====
hdl/tcp_tx_pkg.sv
hdl/tcp_tx_buf.sv
hdl/tcp_tx_packetizer.sv
hdl/tcp_tx_slot.sv
hdl/tcp_tx_sched.sv
hdl/tcp_tx_ctl.sv
verification/tcp_tx_ctl_checker.sv
verification/tcp_tx_ctl_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tcp_tx_ctl_tb
FLIST     ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FLIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

// ==== verification/tcp_tx_ctl_tb.sv ====
`timescale 1ns/1ns

module tcp_tx_ctl_tb import tcp_tx_pkg::*; ();

  localparam int MTU_PLD = 16, SLOTS = 4, BUF_AW = 6, WAIT_TICKS = 8;
  localparam int RETRANS_TICKS = 200, RETRANS_TRIES = 2;
  localparam tcp_num_t INIT_SEQ = 32'hffff_fff0; // wraps during the run

  typedef struct {
    string name;
    int    n;    // bytes pushed
    bit    idle; // close by idle instead of in_snd
    bit    ack;  // full ack after the sends, else partial ack and resends
    int    pkts;
  } row_t;

  row_t rows [4] = '{
    '{"snd_burst", 5, 0, 1, 1},
    '{"idle_odd", 7, 1, 1, 1},
    '{"mtu_split", 60, 0, 1, 4}, // one packet per slot
    '{"retrans", 6, 0, 0, 1}
  };

  logic clk, rst, connected, init, in_val, in_snd, cts, req, sent, send, force_dcn;
  tcp_num_t init_seq, rem_ack, loc_seq, seq;
  logic [7:0] in_dat;
  logic [7:0] pay [64]; // bytes of the current row
  pkt_info_t pld_info;
  strm_t strm;
  integer seed = 32'he8ac_80a3;
  int cycles, limit, n_err;

  tcp_tx_ctl #(.MTU_PLD(MTU_PLD), .SLOTS(SLOTS), .BUF_AW(BUF_AW), .WAIT_TICKS(WAIT_TICKS),
    .RETRANS_TICKS(RETRANS_TICKS), .RETRANS_TRIES(RETRANS_TRIES)) DUT (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // watchdog
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      $display("timeout, DUT stopped responding");
      $display("RESULT: FAIL");
      $fatal(1, "timeout");
    end
  end

  task automatic fail_msg(input string what);
    n_err++;
    $display("%s", what);
    $display("RESULT: FAIL");
    $fatal(1, "check failed");
  endtask

  task automatic check_info(input string name, input pkt_info_t exp, input pkt_info_t act);
    if (exp !== act) begin
      $display("Error %s: expected %h actual %h", name, exp, act);
      fail_msg("packet info mismatch");
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (exp !== act) begin
      $display("Error %s: expected %h actual %h", name, exp, act);
      fail_msg("payload byte mismatch");
    end
  endtask

  task automatic check_num(input string name, input tcp_num_t exp, input tcp_num_t act);
    if (exp !== act) begin
      $display("Error %s: expected %h actual %h", name, exp, act);
      fail_msg("sequence number mismatch");
    end
  endtask

  // reference: big-endian words, odd tail padded with a zero low byte
  function automatic pkt_info_t model_info(input tcp_num_t start, input int off, input int len);
    pkt_info_t p;
    p.start  = start;
    p.length = 16'(len);
    p.stop   = start + 32'(len);
    p.cks    = '0;
    for (int i = 0; i < len; i += 2) begin
      p.cks = cks_add(p.cks, {pay[off + i], (i + 1 < len) ? pay[off + i + 1] : 8'h00});
    end
    return p;
  endfunction

  task automatic push_bytes(input int n, input bit idle);
    int i;
    i = 0;
    in_dat <= pay[0];
    in_val <= 1'b1;
    while (i < n) begin
      @(posedge clk);
      if (cts) begin // taken on this edge
        i++;
        if (i < n) in_dat <= pay[i];
        else in_val <= 1'b0;
      end
    end
    if (!idle) begin
      in_snd <= 1'b1;
      @(posedge clk);
      in_snd <= 1'b0;
    end
  endtask

  // acts as packet builder for one send
  task automatic take_packet(input string name, input int off, input int len);
    int nreq, nrx;
    @(posedge clk);
    while (!send) @(posedge clk);
    check_info(name, model_info(seq + 32'(off), off, len), pld_info);
    req  <= 1'b1;
    nreq = 0;
    nrx  = 0;
    while (nrx < len) begin
      @(posedge clk);
      if (req) nreq++;
      if (nreq == len) req <= 1'b0;
      if (strm.val) begin
        check_byte(name, pay[off + nrx], strm.dat);
        if (strm.sof != (nrx == 0)) fail_msg("sof on the wrong byte");
        if (strm.eof != (nrx == len - 1)) fail_msg("eof on the wrong byte");
        nrx++;
      end
    end
    sent <= 1'b1;
    @(posedge clk);
    sent <= 1'b0;
  endtask

  task automatic take_row(input row_t r);
    int len;
    for (int k = 0; k < r.pkts; k++) begin
      len = (r.n - k * MTU_PLD < MTU_PLD) ? r.n - k * MTU_PLD : MTU_PLD; // last one short
      take_packet(r.name, k * MTU_PLD, len);
    end
  endtask

  initial begin
    rst       = 1'b1;
    connected = 1'b0;
    init      = 1'b0;
    init_seq  = '0;
    in_dat    = '0;
    in_val    = 1'b0;
    in_snd    = 1'b0;
    rem_ack   = '0;
    req       = 1'b0;
    sent      = 1'b0;
    cycles = 0;
    n_err  = 0;
    limit  = RETRANS_TICKS * (RETRANS_TRIES + 2) + 2000; // margin for per-packet overhead
    foreach (rows[r]) limit += rows[r].n;
    repeat (16) @(posedge clk);
    rst      <= 1'b0;
    init     <= 1'b1;
    init_seq <= INIT_SEQ;
    rem_ack  <= INIT_SEQ;
    @(posedge clk);
    if (cts || send || strm.val || force_dcn) fail_msg("outputs not idle after reset");
    init      <= 1'b0;
    connected <= 1'b1;
    seq = INIT_SEQ;
    @(posedge clk);
    foreach (rows[r]) begin
      for (int i = 0; i < 64; i++) pay[i] = 8'($random(seed));
      fork
        push_bytes(rows[r].n, rows[r].idle);
        take_row(rows[r]);
      join
      check_num(rows[r].name, seq + 32'(rows[r].n), loc_seq); // one seq step per byte
      if (rows[r].ack) begin
        if ((rows[r].pkts == SLOTS) && cts) fail_msg("cts high with every slot in use");
        rem_ack <= seq + 32'(rows[r].n);
        @(posedge clk);
        while (!cts) @(posedge clk); // slots released again
      end else begin
        rem_ack <= seq + 32'd2; // partial, packet stays due
        for (int t = 0; t < RETRANS_TRIES; t++) begin
          if (force_dcn) fail_msg("force_dcn raised too early");
          take_row(rows[r]);
        end
        if (!force_dcn) fail_msg("force_dcn not raised after the last retransmission");
      end
      seq = seq + 32'(rows[r].n);
    end
    if (n_err == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule : tcp_tx_ctl_tb

// ==== verification/tcp_tx_ctl_checker.sv ====
`timescale 1ns/1ns

module tcp_tx_ctl_checker import tcp_tx_pkg::*; (
  input logic  clk,
  input logic  rst,
  input logic  send,
  input strm_t strm
);

  logic after_eof; // set between eof and the next send

  always_ff @(posedge clk) begin
    if (rst) after_eof <= 1'b0;
    else if (send) after_eof <= 1'b0;
    else if (strm.val && strm.eof) after_eof <= 1'b1;
  end

  // nothing valid once the payload has ended
  a_quiet_after_eof : assert property (@(posedge clk) disable iff (rst)
    after_eof |-> !strm.val) else $error("stream valid after eof");

  a_send_pulse : assert property (@(posedge clk) disable iff (rst)
    send |=> !send) else $error("send wider than one cycle");

  a_marks_with_val : assert property (@(posedge clk) disable iff (rst)
    (strm.sof || strm.eof) |-> strm.val) else $error("sof or eof without val");

endmodule : tcp_tx_ctl_checker

bind tcp_tx_ctl tcp_tx_ctl_checker chk_inst (.clk, .rst, .send, .strm);

// ==== hdl/tcp_tx_ctl.sv ====
`timescale 1ns/1ns

module tcp_tx_ctl import tcp_tx_pkg::*; #(
  parameter int MTU_PLD       = 1460,
  parameter int SLOTS         = 8,     // power of two
  parameter int BUF_AW        = 13,
  parameter int WAIT_TICKS    = 20,
  parameter int RETRANS_TICKS = 100000,
  parameter int RETRANS_TRIES = 5
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       connected,
  input  logic       init,      // connection (re)start
  input  tcp_num_t   init_seq,
  input  logic [7:0] in_dat,
  input  logic       in_val,
  input  logic       in_snd,
  output logic       cts,
  input  tcp_num_t   rem_ack,
  output logic       send,
  output pkt_info_t  pld_info,
  input  logic       req,
  input  logic       sent,
  output strm_t      strm,
  output logic       force_dcn,
  output tcp_num_t   loc_seq
);

  logic                     wr, full, load;
  logic [$clog2(SLOTS)-1:0] load_slot;
  pkt_info_t                new_info;
  tcp_num_t                 rd_seq, loc_ack;
  logic [7:0]               rd_dat;
  logic [SLOTS-1:0]         present, due, freed, grant, done;
  pkt_info_t                infos [SLOTS];
  logic [7:0]               tries [SLOTS];

  ////////////////////////////////////////////////////////////////////////////
  // byte store and packet creation
  ////////////////////////////////////////////////////////////////////////////

  tcp_tx_buf #(.BUF_AW(BUF_AW)) buf_inst (
    .clk, .rst, .wr, .wr_seq(loc_seq), .wr_dat(in_dat),
    .rd_seq, .loc_ack, .rd_dat, .full
  );

  tcp_tx_packetizer #(.MTU_PLD(MTU_PLD), .SLOTS(SLOTS), .WAIT_TICKS(WAIT_TICKS)) pkt_inst (
    .clk, .rst, .connected, .init, .init_seq, .in_dat, .in_val, .in_snd,
    .full, .slot_present(present), .cts, .loc_seq, .wr, .load, .load_slot, .new_info
  );

  // one tracker per outstanding packet
  for (genvar i = 0; i < SLOTS; i++) begin : g_slot
    tcp_tx_slot #(.RETRANS_TICKS(RETRANS_TICKS)) slot_inst (
      .clk, .rst, .init,
      .load     (load && (load_slot == i)),
      .new_info,
      .rem_ack,
      .grant    (grant[i]),
      .done     (done[i]),
      .present  (present[i]),
      .due      (due[i]),
      .freed    (freed[i]),
      .info     (infos[i]),
      .tries    (tries[i])
    );
  end

  tcp_tx_sched #(.SLOTS(SLOTS), .RETRANS_TRIES(RETRANS_TRIES)) sched_inst (
    .clk, .rst, .init, .init_seq, .due, .freed, .infos, .tries, .req, .sent,
    .rd_dat, .grant, .done, .send, .pld_info, .strm, .rd_seq, .loc_ack, .force_dcn
  );

endmodule : tcp_tx_ctl

// ==== hdl/tcp_tx_sched.sv ====
`timescale 1ns/1ns

module tcp_tx_sched import tcp_tx_pkg::*; #(
  parameter int SLOTS         = 8,
  parameter int RETRANS_TRIES = 5
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             init,
  input  tcp_num_t         init_seq,
  input  logic [SLOTS-1:0] due,
  input  logic [SLOTS-1:0] freed,
  input  pkt_info_t        infos [SLOTS],
  input  logic [7:0]       tries [SLOTS],
  input  logic             req,      // builder pulls one byte per cycle
  input  logic             sent,
  input  logic [7:0]       rd_dat,
  output logic [SLOTS-1:0] grant,
  output logic [SLOTS-1:0] done,
  output logic             send,
  output pkt_info_t        pld_info,
  output strm_t            strm,
  output tcp_num_t         rd_seq,
  output tcp_num_t         loc_ack,
  output logic             force_dcn
);

  localparam int SW = $clog2(SLOTS);

  typedef enum logic [1:0] {idle_s, ann_s, strm_s, wait_s} st_t;
  st_t st;

  logic [SW-1:0] rr, cur, pick_idx;
  logic          pick_ok;
  logic [15:0]   cnt;           // bytes issued to the buffer
  logic          last;
  logic          s_val, s_sof, s_eof;
  tcp_num_t      ack_pend, ack_max; // highest stop freed so far

  // round robin from rr, lowest offset wins
  always_comb begin
    logic [SW-1:0] j;
    pick_ok  = 1'b0;
    pick_idx = rr;
    for (int k = SLOTS - 1; k >= 0; k--) begin
      j = rr + SW'(k); // wraps since SLOTS is a power of two
      if (due[j]) begin
        pick_ok  = 1'b1;
        pick_idx = j;
      end
    end
  end

  // never step the ack pointer back
  always_comb begin
    ack_max = ack_pend;
    for (int i = 0; i < SLOTS; i++) begin
      if (freed[i] && seq_gt(infos[i].stop, ack_max)) ack_max = infos[i].stop;
    end
  end

  assign last = (cnt == pld_info.length - 16'd1);
  assign strm = '{dat: rd_dat, val: s_val, sof: s_sof, eof: s_eof}; // data one cycle after req

  always_ff @(posedge clk) begin
    if (rst || init) begin
      st        <= idle_s;
      rr        <= '0;
      grant     <= '0;
      done      <= '0;
      send      <= 1'b0;
      s_val     <= 1'b0;
      s_sof     <= 1'b0;
      s_eof     <= 1'b0;
      force_dcn <= 1'b0;
      ack_pend  <= rst ? '0 : init_seq;
      loc_ack   <= rst ? '0 : init_seq;
    end else begin
      grant    <= '0;
      done     <= '0;
      send     <= 1'b0;
      s_val    <= 1'b0;
      s_sof    <= 1'b0;
      s_eof    <= 1'b0;
      ack_pend <= ack_max;
      case (st)
        idle_s : begin
          loc_ack <= ack_max; // buffer space released only between packets
          if (pick_ok) begin
            grant    <= SLOTS'(1) << pick_idx;
            cur      <= pick_idx;
            rr       <= pick_idx + 1'b1;
            pld_info <= infos[pick_idx];
            rd_seq   <= infos[pick_idx].start;
            cnt      <= '0;
            if (tries[pick_idx] == 8'(RETRANS_TRIES)) force_dcn <= 1'b1;
            st       <= ann_s;
          end
        end
        ann_s : begin
          send <= 1'b1;
          st   <= strm_s;
        end
        strm_s : begin
          if (req) begin
            s_val  <= 1'b1;
            s_sof  <= (cnt == '0);
            s_eof  <= last;
            cnt    <= cnt + 16'd1;
            rd_seq <= rd_seq + 32'd1;
            if (last) st <= wait_s;
          end
          if (sent) begin // builder may abort early
            done <= SLOTS'(1) << cur;
            st   <= idle_s;
          end
        end
        default : begin // wait_s
          if (sent) begin
            done <= SLOTS'(1) << cur;
            st   <= idle_s;
          end
        end
      endcase
    end
  end

endmodule : tcp_tx_sched

// ==== hdl/tcp_tx_slot.sv ====
`timescale 1ns/1ns

module tcp_tx_slot import tcp_tx_pkg::*; #(
  parameter int RETRANS_TICKS = 100000 // cycles between tries
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       init,
  input  logic       load,
  input  pkt_info_t  new_info,
  input  tcp_num_t   rem_ack,
  input  logic       grant,    // scheduler picked this slot
  input  logic       done,     // builder reported sent
  output logic       present,
  output logic       due,
  output logic       freed,    // one-cycle pulse, info still valid
  output pkt_info_t  info,
  output logic [7:0] tries
);

  localparam int TW = $clog2(RETRANS_TICKS + 1);

  logic [TW-1:0] timer;
  logic          busy;   // between grant and done
  logic          acked;
  logic          expired;

  // whole packet covered once stop - rem_ack <= 0
  assign acked   = present && !seq_gt(info.stop, rem_ack);
  assign expired = (timer == TW'(RETRANS_TICKS));
  assign due     = present && !acked && expired;

  always_ff @(posedge clk) begin
    freed <= 1'b0;
    if (rst || init) begin
      present <= 1'b0;
      busy    <= 1'b0;
      tries   <= '0;
      timer   <= '0;
    end else if (load) begin
      present <= 1'b1;
      info    <= new_info;
      busy    <= 1'b0;
      tries   <= '0;
      timer   <= TW'(RETRANS_TICKS); // first send right away
    end else if (present) begin
      if (acked) begin
        present <= 1'b0;
        freed   <= 1'b1;
      end
      if (grant) begin
        busy  <= 1'b1;
        timer <= '0;
        tries <= tries + 8'd1;
      end else if (done) begin
        busy <= 1'b0;
      end else if (!busy && !expired) begin
        timer <= timer + 1'b1; // measured from end of last transmission
      end
    end
  end

endmodule : tcp_tx_slot

// ==== hdl/tcp_tx_packetizer.sv ====
`timescale 1ns/1ns

module tcp_tx_packetizer import tcp_tx_pkg::*; #(
  parameter int MTU_PLD    = 1460, // max payload per packet
  parameter int SLOTS      = 8,
  parameter int WAIT_TICKS = 20    // idle cycles before a packet is closed
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     connected,
  input  logic                     init,
  input  tcp_num_t                 init_seq,
  input  logic [7:0]               in_dat,
  input  logic                     in_val,
  input  logic                     in_snd,       // force close
  input  logic                     full,         // from byte buffer
  input  logic [SLOTS-1:0]         slot_present,
  output logic                     cts,
  output tcp_num_t                 loc_seq,      // seq of next user byte
  output logic                     wr,
  output logic                     load,
  output logic [$clog2(SLOTS)-1:0] load_slot,
  output pkt_info_t                new_info
);

  localparam int IW = $clog2(WAIT_TICKS + 1);

  typedef enum logic {idle_s, pend_s} st_t;
  st_t st;

  tcp_num_t                 start_q, start_cur;
  logic [15:0]              len, len_nxt;      // bytes in open packet
  logic [31:0]              sum, sum_nxt, cks_fin;
  logic [7:0]               hi_byte, hi_nxt;   // even byte waiting for its pair
  logic [IW-1:0]            idle_cnt;
  logic [SLOTS-1:0]         occupied;
  logic [$clog2(SLOTS)-1:0] free_idx;
  logic                     take, open, close;

  // slot loaded this cycle is not yet flagged present
  assign occupied = slot_present | (load ? (SLOTS'(1) << load_slot) : '0);
  assign cts      = connected && !(&occupied) && !full;
  assign take     = in_val && cts;
  assign wr       = take;

  // lowest free slot
  always_comb begin
    free_idx = '0;
    for (int i = SLOTS - 1; i >= 0; i--) begin
      if (!occupied[i]) free_idx = i[$clog2(SLOTS)-1:0];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // next packet state, includes a byte taken this cycle
  ////////////////////////////////////////////////////////////////////////////

  assign start_cur = (st == pend_s) ? start_q : loc_seq;
  assign len_nxt   = len + 16'(take);
  assign hi_nxt    = (take && !len[0]) ? in_dat : hi_byte;
  assign sum_nxt   = (take && len[0]) ? cks_add(sum, {hi_byte, in_dat}) : sum;
  assign cks_fin   = len_nxt[0] ? cks_add(sum_nxt, {hi_nxt, 8'h00}) : sum_nxt; // pad odd tail
  assign open      = (st == pend_s) || take;

  assign close = open && (in_snd ||
                          (!in_val && idle_cnt == IW'(WAIT_TICKS - 1)) ||
                          (len_nxt == 16'(MTU_PLD)) ||
                          full);

  always_ff @(posedge clk) begin
    if (rst) loc_seq <= '0;
    else if (init) loc_seq <= init_seq; // new connection
    else if (take) loc_seq <= loc_seq + 32'd1;
  end

  always_ff @(posedge clk) begin
    if (rst || init) begin
      st       <= idle_s;
      len      <= '0;
      sum      <= '0;
      idle_cnt <= '0;
      load     <= 1'b0;
    end else begin
      load    <= close; // one cycle after close
      hi_byte <= hi_nxt;
      if (close) begin
        new_info  <= '{start: start_cur, stop: start_cur + 32'(len_nxt),
                       length: len_nxt, cks: cks_fin};
        load_slot <= free_idx;
        st        <= idle_s;
        len       <= '0;
        sum       <= '0;
        idle_cnt  <= '0;
      end else if (open) begin
        st       <= pend_s;
        start_q  <= start_cur;
        len      <= len_nxt;
        sum      <= sum_nxt;
        idle_cnt <= in_val ? '0 : idle_cnt + 1'b1; // restart on any valid
      end
    end
  end

endmodule : tcp_tx_packetizer

// ==== hdl/tcp_tx_buf.sv ====
`timescale 1ns/1ns

module tcp_tx_buf import tcp_tx_pkg::*; #(
  parameter int BUF_AW = 10 // log2 of buffer bytes
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       wr,      // user byte accepted
  input  tcp_num_t   wr_seq,  // seq of that byte
  input  logic [7:0] wr_dat,
  input  tcp_num_t   rd_seq,  // seq of byte to stream
  input  tcp_num_t   loc_ack, // everything before this may be overwritten
  output logic [7:0] rd_dat,  // one cycle after rd_seq
  output logic       full
);

  localparam int SIZE = 2 ** BUF_AW;

  logic [7:0]      mem [SIZE];
  tcp_num_t        used;  // bytes held between loc_ack and wr_seq
  logic [BUF_AW:0] space; // free bytes left

  // occupancy straight from the two pointers
  assign used  = wr_seq - loc_ack;
  assign space = (BUF_AW + 1)'(SIZE) - used[BUF_AW:0];
  // used never passes SIZE since cts drops at zero space
  assign full  = (space == '0);

  // write port, address is the seq number mod buffer size
  always_ff @(posedge clk) begin
    if (wr) mem[wr_seq[BUF_AW-1:0]] <= wr_dat;
  end

  // read port, registered
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_dat <= '0;
    end else begin
      rd_dat <= mem[rd_seq[BUF_AW-1:0]];
    end
  end

endmodule : tcp_tx_buf

// ==== hdl/tcp_tx_pkg.sv ====
package tcp_tx_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // sequence space
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [31:0] tcp_num_t; // seq and ack numbers wrap modulo 2^32

  // packet bookkeeping kept per slot
  typedef struct packed {
    tcp_num_t    start;  // seq of first payload byte
    tcp_num_t    stop;   // expected ack (start + length)
    logic [15:0] length; // payload bytes
    logic [31:0] cks;    // unfolded sum of big-endian 16-bit words
  } pkt_info_t;

  // raw payload stream towards the packet builder
  typedef struct packed {
    logic [7:0] dat;
    logic       val;
    logic       sof; // first byte of payload
    logic       eof; // last byte of payload
  } strm_t;

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  // one 16-bit word into the running sum, carries stay in the upper half
  function automatic logic [31:0] cks_add(input logic [31:0] sum, input logic [15:0] word);
    return sum + {16'h0000, word};
  endfunction

  // a strictly after b in modular seq space
  function automatic logic seq_gt(input tcp_num_t a, input tcp_num_t b);
    tcp_num_t d;
    d = a - b;
    return !d[31] && (d != '0);
  endfunction

endpackage : tcp_tx_pkg
